// File: hdl/modexp_pkg.sv
/* Shared widths, vector types and controller states for the modular exponentiation engine.
   Imported by every RTL module of the engine. */

`default_nettype none

package modexp_pkg;

    // Modulus and all values reduced by it
    localparam int mod_width = 16;

    // Exponent width, one square-and-multiply round per bit
    localparam int exp_width = 4;

    // Step index must reach mod_width - 1
    localparam int step_width = 4;

    typedef logic [mod_width-1:0]  mod_word_t;
    typedef logic [exp_width-1:0]  exp_word_t;
    typedef logic [step_width-1:0] step_idx_t;

    // Controller sequence, see modexp_ctrl
    typedef enum logic [2:0] {
        st_idle,
        st_load,
        st_check,
        st_mul,
        st_sqr,
        st_shift,
        st_done
    } modexp_state_t;

endpackage

`default_nettype wire

// File: hdl/modmul_step_timer.sv
/* Step counter for one modular multiplication. Started by mul_start, it walks
   the operand bit index from the top bit down to bit 0. */

`timescale 1ns/100ps
`default_nettype none

module modmul_step_timer
    import modexp_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      mul_start,
    output logic      step_en,
    output step_idx_t step_idx,
    output logic      step_last
);

    logic      active;
    step_idx_t cnt;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            active <= 1'b0;
            cnt    <= '0;
        end else if (mul_start) begin
            active <= 1'b1;
            cnt    <= step_idx_t'(mod_width - 1);
        end else if (active) begin
            if (cnt == '0)
                active <= 1'b0;
            else
                cnt <= cnt - 1'b1;
        end
    end

    assign step_en   = active;
    assign step_idx  = cnt;
    assign step_last = active && (cnt == '0);

    a_no_restart: assert property (@(posedge clk) disable iff (rst)
        mul_start |-> !step_en);

endmodule

`default_nettype wire

// File: hdl/modmul_unit.sv
/* Interleaved shift-add modular multiplier, op_a times op_b mod modulus.
   One bit of op_a per enabled step, MSB first; product is the partial remainder. */

`timescale 1ns/100ps
`default_nettype none

module modmul_unit
    import modexp_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      step_en,
    input  step_idx_t step_idx,
    input  logic      mul_start,
    input  mod_word_t op_a,
    input  mod_word_t op_b,
    input  mod_word_t modulus,
    output mod_word_t product
);

    // Partial remainder, always below the modulus
    mod_word_t part;

    // One extra bit so doubling and adding keep their carry
    logic [mod_width:0] mod_ext;
    logic [mod_width:0] dbl;
    logic [mod_width:0] dbl_red;
    logic [mod_width:0] addend;
    logic [mod_width:0] sum;
    logic [mod_width:0] sum_red;

    assign mod_ext = {1'b0, modulus};

    always_comb begin
        // Doubling: part < m gives dbl < 2m, one subtract is enough
        dbl = {part, 1'b0};
        if (dbl >= mod_ext)
            dbl_red = dbl - mod_ext;
        else
            dbl_red = dbl;

        if (op_a[step_idx])
            addend = {1'b0, op_b};
        else
            addend = '0;

        // op_b < m as well, so the sum stays below 2m
        sum = dbl_red + addend;
        if (sum >= mod_ext)
            sum_red = sum - mod_ext;
        else
            sum_red = sum;
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            part <= '0;
        end else if (mul_start) begin
            part <= '0;
        end else if (step_en) begin
            part <= sum_red[mod_width-1:0];
        end
    end

    assign product = part;

endmodule

`default_nettype wire

// File: hdl/modexp_datapath.sv
/* Operand registers of the exponentiation: modulus, accumulator, base,
   exponent shift register and result, plus multiplier operand selection. */

`timescale 1ns/100ps
`default_nettype none

module modexp_datapath
    import modexp_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      load_en,
    input  mod_word_t message,
    input  mod_word_t modulus,
    input  exp_word_t exponent,
    input  logic      sqr_sel,
    input  logic      write_acc,
    input  logic      write_base,
    input  logic      shift_en,
    input  logic      result_en,
    input  mod_word_t product,
    output mod_word_t op_a,
    output mod_word_t op_b,
    output mod_word_t mod_reg,
    output logic      exp_lsb,
    output logic      exp_zero,
    output mod_word_t result
);

    mod_word_t acc;
    mod_word_t base;
    exp_word_t exp_sr;

    always_ff @(posedge clk) begin
        if (load_en) begin
            mod_reg <= modulus;
            base    <= message;
            acc     <= mod_word_t'(1);
        end else begin
            if (write_acc)
                acc <= product;
            if (write_base)
                base <= product;
        end
    end

    // Exponent bits consumed LSB first
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            exp_sr <= '0;
            result <= '0;
        end else begin
            if (load_en)
                exp_sr <= exponent;
            else if (shift_en)
                exp_sr <= exp_sr >> 1;
            if (result_en)
                result <= acc;
        end
    end

    assign op_a     = sqr_sel ? base : acc;
    assign op_b     = base;
    assign exp_lsb  = exp_sr[0];
    assign exp_zero = (exp_sr == '0);

    // Caller keeps the message reduced, the engine never reduces it
    a_operands_ok: assert property (@(posedge clk) disable iff (rst)
        load_en |-> (modulus >= mod_word_t'(2)) && (message < modulus));

endmodule

`default_nettype wire

// File: hdl/modexp_ctrl.sv
/* Controller FSM for square-and-multiply: request handshake, multiply/square
   sequencing and response handshake. */

`timescale 1ns/100ps
`default_nettype none

module modexp_ctrl
    import modexp_pkg::*;
(
    input  logic clk,
    input  logic rst,
    input  logic req_valid,
    output logic req_ready,
    output logic rsp_valid,
    input  logic rsp_ready,
    input  logic exp_lsb,
    input  logic exp_zero,
    input  logic step_last,
    output logic load_en,
    output logic mul_start,
    output logic sqr_sel,
    output logic write_acc,
    output logic write_base,
    output logic shift_en,
    output logic result_en
);

    modexp_state_t state;
    modexp_state_t state_nxt;

    // Keeps req_ready low in the first cycle out of reset
    logic armed;
    // Write strobe cycle, one cycle after the last multiplier step
    logic wr_pend;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state   <= st_idle;
            armed   <= 1'b0;
            wr_pend <= 1'b0;
        end else begin
            state   <= state_nxt;
            armed   <= 1'b1;
            wr_pend <= step_last;
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            st_idle:  if (req_valid && req_ready) state_nxt = st_load;
            st_load:  state_nxt = st_check;
            st_check: begin
                if (exp_zero)
                    state_nxt = st_done;
                else if (exp_lsb)
                    state_nxt = st_mul;
                else
                    state_nxt = st_sqr;
            end
            st_mul:   if (wr_pend) state_nxt = st_sqr;
            st_sqr:   if (wr_pend) state_nxt = st_shift;
            st_shift: state_nxt = st_check;
            st_done:  if (rsp_ready) state_nxt = st_idle;
            default:  state_nxt = st_idle;
        endcase
    end

    assign req_ready = (state == st_idle) && armed;
    assign load_en   = req_valid && req_ready;

    // Square follows straight after the multiply write, so restart there too
    assign mul_start = ((state == st_check) && !exp_zero) || ((state == st_mul) && wr_pend);
    assign sqr_sel    = (state == st_sqr);
    assign write_acc  = (state == st_mul) && wr_pend;
    assign write_base = (state == st_sqr) && wr_pend;
    assign shift_en   = (state == st_shift);

    // Result captured on the edge into st_done
    assign result_en = (state == st_check) && exp_zero;
    assign rsp_valid = (state == st_done);

    a_rsp_hold: assert property (@(posedge clk) disable iff (rst)
        rsp_valid && !rsp_ready |=> rsp_valid);

    a_write_excl: assert property (@(posedge clk) disable iff (rst)
        !(write_acc && write_base));

endmodule

`default_nettype wire

// File: hdl/modexp_top.sv
/* Top of the modular exponentiation engine, result = message ** exponent mod modulus.
   Requests and responses each use a valid/ready handshake. */

`timescale 1ns/100ps
`default_nettype none

module modexp_top
    import modexp_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      req_valid,
    output logic      req_ready,
    input  mod_word_t message,
    input  mod_word_t modulus,
    input  exp_word_t exponent,
    output logic      rsp_valid,
    input  logic      rsp_ready,
    output mod_word_t result
);

    logic      load_en;
    logic      mul_start;
    logic      sqr_sel;
    logic      write_acc;
    logic      write_base;
    logic      shift_en;
    logic      result_en;
    logic      exp_lsb;
    logic      exp_zero;
    logic      step_en;
    logic      step_last;
    step_idx_t step_idx;
    mod_word_t op_a;
    mod_word_t op_b;
    mod_word_t mod_reg;
    mod_word_t product;

    modexp_ctrl u_ctrl (
        .clk        (clk),
        .rst        (rst),
        .req_valid  (req_valid),
        .req_ready  (req_ready),
        .rsp_valid  (rsp_valid),
        .rsp_ready  (rsp_ready),
        .exp_lsb    (exp_lsb),
        .exp_zero   (exp_zero),
        .step_last  (step_last),
        .load_en    (load_en),
        .mul_start  (mul_start),
        .sqr_sel    (sqr_sel),
        .write_acc  (write_acc),
        .write_base (write_base),
        .shift_en   (shift_en),
        .result_en  (result_en)
    );

    modmul_step_timer u_timer (
        .clk       (clk),
        .rst       (rst),
        .mul_start (mul_start),
        .step_en   (step_en),
        .step_idx  (step_idx),
        .step_last (step_last)
    );

    // Multiplier reduces by the registered modulus
    modmul_unit u_mul (
        .clk       (clk),
        .rst       (rst),
        .step_en   (step_en),
        .step_idx  (step_idx),
        .mul_start (mul_start),
        .op_a      (op_a),
        .op_b      (op_b),
        .modulus   (mod_reg),
        .product   (product)
    );

    modexp_datapath u_dp (
        .clk        (clk),
        .rst        (rst),
        .load_en    (load_en),
        .message    (message),
        .modulus    (modulus),
        .exponent   (exponent),
        .sqr_sel    (sqr_sel),
        .write_acc  (write_acc),
        .write_base (write_base),
        .shift_en   (shift_en),
        .result_en  (result_en),
        .product    (product),
        .op_a       (op_a),
        .op_b       (op_b),
        .mod_reg    (mod_reg),
        .exp_lsb    (exp_lsb),
        .exp_zero   (exp_zero),
        .result     (result)
    );

endmodule

`default_nettype wire

// File: dv/modexp_tb.sv
/* Self-checking testbench for modexp_top: fixed, random, back-pressured and back-to-back
   requests, checked by concurrent assertions against a scoreboard of model results. */

`timescale 1ns/100ps
`default_nettype none

module modexp_tb
    import modexp_pkg::*;
();

    localparam int req_timeout = 500;
    localparam int rsp_timeout = 1000;
    localparam int num_random  = 200;
    localparam int num_burst   = 24;

    logic      clk;
    logic      rst;
    logic      req_valid;
    logic      req_ready;
    mod_word_t message;
    mod_word_t modulus;
    exp_word_t exponent;
    logic      rsp_valid;
    logic      rsp_ready;
    mod_word_t result;

    // Expected results in request order
    mod_word_t sb_q[$];
    mod_word_t sb_head = '0;
    int        sb_count = 0;
    int        since_rst = 0;
    int        check_errors = 0;
    int        order_errors = 0;
    int        timeouts = 0;
    int        accepted = 0;
    int        responses = 0;

    modexp_top uut (
        .clk       (clk),
        .rst       (rst),
        .req_valid (req_valid),
        .req_ready (req_ready),
        .message   (message),
        .modulus   (modulus),
        .exponent  (exponent),
        .rsp_valid (rsp_valid),
        .rsp_ready (rsp_ready),
        .result    (result)
    );

    always #2 clk = ~clk;

    // Repeated multiplication rather than square-and-multiply
    function automatic int unsigned model_pow(int unsigned msg, int unsigned md, int unsigned e);
        int unsigned r;
        int unsigned i;
        r = 1 % md;
        for (i = 0; i < e; i++)
            r = (r * msg) % md;
        return r;
    endfunction

    always @(posedge clk or posedge rst) begin
        if (rst)
            since_rst <= 0;
        else if (since_rst < 2)
            since_rst <= since_rst + 1;
    end

    // Pop on each response, push the model result on each accepted request
    always @(posedge clk) begin
        if (!rst) begin
            if (rsp_valid && rsp_ready) begin
                if (sb_q.size() > 0)
                    void'(sb_q.pop_front());
                responses++;
            end
            if (req_valid && req_ready) begin
                sb_q.push_back(mod_word_t'(model_pow(32'(message), 32'(modulus),
                                                     32'(exponent))));
                accepted++;
            end
        end
        sb_count <= sb_q.size();
        sb_head  <= (sb_q.size() > 0) ? sb_q[0] : '0;
    end

    a_reset_idle: assert property (@(posedge clk) disable iff (rst)
        since_rst == 0 |-> !req_ready && !rsp_valid)
        else begin
            check_errors++;
            $display("CHECK FAILED at %0t: handshake outputs not idle after reset", $time);
        end

    a_ready_after_reset: assert property (@(posedge clk) disable iff (rst)
        since_rst == 1 |-> req_ready && !rsp_valid)
        else begin
            check_errors++;
            $display("CHECK FAILED at %0t: req_ready did not rise after reset", $time);
        end

    a_result_match: assert property (@(posedge clk) disable iff (rst)
        rsp_valid && rsp_ready |-> sb_count != 0 && result == sb_head)
        else begin
            check_errors++;
            $display("CHECK FAILED at %0t: result %0d, expected %0d, %0d pending", $time,
                     $sampled(result), $sampled(sb_head), $sampled(sb_count));
        end

    // Stalled response keeps its value and blocks new requests
    a_rsp_stall: assert property (@(posedge clk) disable iff (rst)
        rsp_valid && !rsp_ready |=> rsp_valid && $stable(result) && !req_ready)
        else begin
            check_errors++;
            $display("CHECK FAILED at %0t: response changed while stalled", $time);
        end

    task automatic report_and_finish();
        $display("check errors: %0d, order errors: %0d, timeouts: %0d, requests: %0d, %s %0d",
                 check_errors, order_errors, timeouts, accepted, "responses:", responses);
        if (check_errors == 0 && order_errors == 0 && timeouts == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    endtask

    task automatic send_request(input mod_word_t msg, input mod_word_t md, input exp_word_t e);
        int waited;
        waited    = 0;
        req_valid = 1'b1;
        message   = msg;
        modulus   = md;
        exponent  = e;
        @(posedge clk);
        while (!req_ready && waited < req_timeout) begin
            @(posedge clk);
            waited++;
        end
        if (!req_ready) begin
            $display("Timeout: request not accepted within %0d cycles", req_timeout);
            timeouts++;
        end
        #0.5;
        req_valid = 1'b0;
    endtask

    task automatic take_response(input int hold);
        int waited;
        waited    = 0;
        rsp_ready = 1'b0;
        @(posedge clk);
        while (!rsp_valid && waited < rsp_timeout) begin
            @(posedge clk);
            waited++;
        end
        if (!rsp_valid) begin
            $display("Timeout: no response within %0d cycles", rsp_timeout);
            timeouts++;
            #0.5;
        end else begin
            repeat (hold) @(posedge clk);
            #0.5;
            rsp_ready = 1'b1;
            @(posedge clk);
            #0.5;
            rsp_ready = 1'b0;
        end
    endtask

    task automatic draw_operands(output mod_word_t msg, output mod_word_t md,
                                 output exp_word_t e);
        md  = mod_word_t'($urandom_range(65535, 2));
        msg = mod_word_t'($urandom % 32'(md));
        e   = exp_word_t'($urandom % 16);
    endtask

    // Requests back to back with rsp_ready held high, then drain
    task automatic run_burst();
        mod_word_t msg;
        mod_word_t md;
        exp_word_t e;
        int        waited;
        rsp_ready = 1'b1;
        for (int n = 0; n < num_burst && timeouts == 0; n++) begin
            draw_operands(msg, md, e);
            send_request(msg, md, e);
        end
        waited = 0;
        @(posedge clk);
        while (sb_count > 0 && waited < rsp_timeout) begin
            @(posedge clk);
            waited++;
        end
        if (sb_count > 0) begin
            $display("Timeout: burst responses still pending after %0d cycles", rsp_timeout);
            timeouts++;
        end
        #0.5;
        rsp_ready = 1'b0;
    endtask

    initial begin
        mod_word_t msg;
        mod_word_t md;
        exp_word_t e;
        int        hold;
        void'($urandom(32'h5b148746));
        clk       = 1'b0;
        rst       = 1'b1;
        req_valid = 1'b0;
        message   = '0;
        modulus   = '0;
        exponent  = '0;
        rsp_ready = 1'b0;
        repeat (16) @(posedge clk);
        #0.5;
        rst = 1'b0;

        // Fixed cases plus the extremes of the modulus range
        send_request(16'd123, 16'd1000, 4'd0);
        take_response(0);
        send_request(16'd4321, 16'd60000, 4'd1);
        take_response(0);
        send_request(16'd0, 16'd977, 4'd9);
        take_response(0);
        send_request(16'd5, 16'd2021, 4'd13);
        take_response(0);
        send_request(16'd65534, 16'd65535, 4'd15);
        take_response(0);
        send_request(16'd1, 16'd2, 4'd15);
        take_response(0);

        // Every fourth response is stalled for a few cycles
        for (int n = 0; n < num_random && timeouts == 0; n++) begin
            draw_operands(msg, md, e);
            hold = (n % 4 == 3) ? int'($urandom_range(12, 1)) : 0;
            send_request(msg, md, e);
            take_response(hold);
        end

        run_burst();

        assert (accepted == responses && sb_count == 0)
        else begin
            order_errors++;
            $display("CHECK FAILED at %0t: %0d requests accepted, %0d responses taken",
                     $time, accepted, responses);
        end
        report_and_finish();
    end

endmodule

`default_nettype wire

// File: compile.f
hdl/modexp_pkg.sv
hdl/modmul_step_timer.sv
hdl/modmul_unit.sv
hdl/modexp_datapath.sv
hdl/modexp_ctrl.sv
hdl/modexp_top.sv
dv/modexp_tb.sv

// File: Makefile
# Verilator lint, build and run for the modular exponentiation engine

VERILATOR ?= verilator
TOP       ?= modexp_tb
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --timing --assert
PASS_LINE ?= >>> PASS

SIM_BIN := $(BUILD_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST))

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

build: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

# Status comes from the search for the pass line in the output
sim: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF -- '$(PASS_LINE)'

clean:
	rm -rf $(BUILD_DIR)
